// File: Makefile
VERILATOR ?= verilator
TOP       ?= codec_cfg_tb
FILELIST  ?= codec_cfg.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "No result in log"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: codec_cfg.f
+incdir+hdl
hdl/codec_cfg_pkg.sv
hdl/cfg_fifo.sv
hdl/cfg_sequencer.sv
hdl/i2c_write_engine.sv
hdl/cfg_status.sv
hdl/codec_cfg_top.sv
testbench/tb_clock_gen.sv
testbench/codec_cfg_assertions.sv
testbench/codec_cfg_tb.sv

// File: hdl/cfg_fifo.sv
`include "codec_cfg_defines.svh"

module cfg_fifo #(
    parameter type T = logic [15:0]
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_valid,
    input  T     i_data,
    output logic o_ready,
    output logic o_valid,
    output T     o_data,
    input  logic i_ready
);
    localparam int AW = $clog2(`CFG_FIFO_DEPTH);
    localparam logic [AW:0] FULL = (AW + 1)'(`CFG_FIFO_DEPTH);

    T              mem [`CFG_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign o_ready = (count != FULL);
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];
    assign wr_en   = i_valid && o_ready;
    assign rd_en   = o_valid && i_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) mem[wr_ptr] <= i_data;
    end

endmodule

// File: hdl/cfg_sequencer.sv
`include "codec_cfg_defines.svh"

module cfg_sequencer import codec_cfg_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_start,
    input  logic      i_host_valid,
    input  cfg_word_t i_host_word,
    output logic      o_host_ready,
    output logic      o_cmd_valid,
    output i2c_cmd_t  o_cmd,
    input  logic      i_cmd_ready
);
    localparam int IW = $clog2(`CFG_INIT_LEN);
    localparam logic [IW-1:0] IDX_LAST = IW'(`CFG_INIT_LEN - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_INIT,
        S_HOST
    } state_t;

    state_t        state;
    logic [IW-1:0] idx;     // Next table entry

    // Command source select
    always_comb begin
        o_cmd        = '{word: i_host_word, from_init: 1'b0};
        o_cmd_valid  = 1'b0;
        o_host_ready = 1'b0;
        case (state)
            S_INIT: begin
                o_cmd       = '{word: INIT_TABLE[idx], from_init: 1'b1};
                o_cmd_valid = 1'b1;
            end
            S_HOST: begin
                o_cmd_valid  = i_host_valid;
                o_host_ready = i_cmd_ready;  // Host sees the FIFO directly
            end
            default: begin
                o_cmd_valid = 1'b0;          // Nothing before first start
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
            idx   <= '0;
        end else if (i_start) begin
            state <= S_INIT;                 // Restart from entry 0
            idx   <= '0;
        end else if (state == S_INIT && i_cmd_ready) begin
            if (idx == IDX_LAST) begin
                state <= S_HOST;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

// File: hdl/cfg_status.sv
`include "codec_cfg_defines.svh"

module cfg_status import codec_cfg_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    input  logic        i_done_pulse,
    input  i2c_cmd_t    i_done_cmd,
    input  logic [2:0]  i_done_nack,
    output logic        o_res_valid,
    output i2c_result_t o_res,
    output logic        o_init_done,
    output logic        o_init_error
);
    localparam int CW = $clog2(`CFG_INIT_LEN + 1);
    localparam logic [CW-1:0] INIT_LAST = CW'(`CFG_INIT_LEN - 1);

    logic [CW-1:0] init_cnt;    // Init results seen since start
    logic          init_hit;

    assign init_hit = i_done_pulse && i_done_cmd.from_init && !o_init_done;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_res_valid  <= 1'b0;
            init_cnt     <= '0;
            o_init_done  <= 1'b0;
            o_init_error <= 1'b0;
        end else begin
            o_res_valid <= i_done_pulse;    // One write per transaction
            if (i_start) begin
                init_cnt     <= '0;
                o_init_done  <= 1'b0;
                o_init_error <= 1'b0;
            end else if (init_hit) begin
                init_cnt <= init_cnt + 1'b1;
                if (i_done_nack != 3'b000) o_init_error <= 1'b1;
                if (init_cnt == INIT_LAST) o_init_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_done_pulse) begin
            o_res <= '{word: i_done_cmd.word, from_init: i_done_cmd.from_init,
                       nack: i_done_nack};
        end
    end

endmodule

// File: hdl/codec_cfg_defines.svh
`ifndef CODEC_CFG_DEFINES_SVH
`define CODEC_CFG_DEFINES_SVH

// System clocks per quarter of an SCL period
`define CFG_I2C_QTR 4

// Entries per FIFO, power of two
`define CFG_FIFO_DEPTH 4

// Codec 7-bit bus address
`define CFG_DEV_ADDR 7'h1A

// Registers written by the init sequence
`define CFG_INIT_LEN 7

`endif

// File: hdl/codec_cfg_pkg.sv
`include "codec_cfg_defines.svh"

package codec_cfg_pkg;

    // One codec register write
    typedef struct packed {
        logic [6:0] reg_addr;
        logic [8:0] reg_data;
    } cfg_word_t;

    typedef struct packed {
        cfg_word_t word;
        logic      from_init;   // Entry came from INIT_TABLE
    } i2c_cmd_t;

    typedef struct packed {
        cfg_word_t  word;
        logic       from_init;
        logic [2:0] nack;       // Bit 2 is the address byte
    } i2c_result_t;

    // Codec bring-up order, index 0 goes out first
    localparam cfg_word_t INIT_TABLE [`CFG_INIT_LEN] = '{
        '{7'h0F, 9'h000},   // Reset
        '{7'h04, 9'h015},   // Analogue path
        '{7'h05, 9'h000},   // Digital path
        '{7'h06, 9'h000},   // Power down
        '{7'h07, 9'h042},   // Interface format
        '{7'h08, 9'h019},   // Sampling
        '{7'h09, 9'h001}    // Active
    };

endpackage

// File: hdl/codec_cfg_top.sv
module codec_cfg_top import codec_cfg_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    input  logic        i_host_valid,
    input  cfg_word_t   i_host_word,
    output logic        o_host_ready,
    output logic        o_res_valid,
    output i2c_result_t o_res,
    input  logic        i_res_ready,
    output logic        o_scl,
    output logic        o_sda_low,
    input  logic        i_sda,
    output logic        o_init_done,
    output logic        o_init_error
);
    i2c_cmd_t    seq_cmd;
    logic        seq_valid;
    logic        seq_ready;
    i2c_cmd_t    eng_cmd;
    logic        eng_valid;
    logic        eng_ready;
    logic        done_pulse;
    i2c_cmd_t    done_cmd;
    logic [2:0]  done_nack;
    i2c_result_t stat_res;
    logic        stat_valid;
    logic        res_in_ready;
    logic        res_space;

    // A result still on its way into the FIFO counts as occupied
    assign res_space = res_in_ready && !stat_valid;

    cfg_sequencer cfg_sequencer_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_host_valid (i_host_valid),
        .i_host_word  (i_host_word),
        .o_host_ready (o_host_ready),
        .o_cmd_valid  (seq_valid),
        .o_cmd        (seq_cmd),
        .i_cmd_ready  (seq_ready)
    );

    cfg_fifo #(.T(i2c_cmd_t)) cmd_fifo_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (seq_valid),
        .i_data  (seq_cmd),
        .o_ready (seq_ready),
        .o_valid (eng_valid),
        .o_data  (eng_cmd),
        .i_ready (eng_ready)
    );

    i2c_write_engine i2c_write_engine_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd_valid  (eng_valid),
        .i_cmd        (eng_cmd),
        .o_cmd_ready  (eng_ready),
        .i_res_space  (res_space),
        .o_scl        (o_scl),
        .o_sda_low    (o_sda_low),
        .i_sda        (i_sda),
        .o_done_pulse (done_pulse),
        .o_done_cmd   (done_cmd),
        .o_done_nack  (done_nack)
    );

    cfg_status cfg_status_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_done_pulse (done_pulse),
        .i_done_cmd   (done_cmd),
        .i_done_nack  (done_nack),
        .o_res_valid  (stat_valid),
        .o_res        (stat_res),
        .o_init_done  (o_init_done),
        .o_init_error (o_init_error)
    );

    cfg_fifo #(.T(i2c_result_t)) res_fifo_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (stat_valid),
        .i_data  (stat_res),
        .o_ready (res_in_ready),
        .o_valid (o_res_valid),
        .o_data  (o_res),
        .i_ready (i_res_ready)
    );

endmodule

// File: hdl/i2c_write_engine.sv
`include "codec_cfg_defines.svh"

module i2c_write_engine import codec_cfg_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_cmd_valid,
    input  i2c_cmd_t   i_cmd,
    output logic       o_cmd_ready,
    input  logic       i_res_space,
    output logic       o_scl,
    output logic       o_sda_low,
    input  logic       i_sda,
    output logic       o_done_pulse,
    output i2c_cmd_t   o_done_cmd,
    output logic [2:0] o_done_nack
);
    localparam int QW = $clog2(`CFG_I2C_QTR + 1);
    localparam logic [QW-1:0] Q_LAST = QW'(`CFG_I2C_QTR - 1);
    localparam logic [4:0] SLOT_START = 5'd0;
    localparam logic [4:0] SLOT_STOP  = 5'd28;

    logic          busy;
    logic [QW-1:0] qcnt;        // Cycles within a quarter
    logic [1:0]    phase;       // Quarter within an SCL period
    logic [4:0]    slot;        // 0 START, 1..27 frame bits, 28 STOP
    logic [26:0]   frame;       // MSB is the bit on the wire
    i2c_cmd_t      cmd_q;
    logic [2:0]    nack_q;
    logic          accept;
    logic          qtr_end;
    logic          slot_end;
    logic          is_bit_slot;
    logic          sample_pt;

    assign o_cmd_ready  = !busy && i_res_space;
    assign accept       = o_cmd_ready && i_cmd_valid;
    assign qtr_end      = (qcnt == Q_LAST);
    assign slot_end     = qtr_end && (phase == 2'd3);
    assign is_bit_slot  = (slot != SLOT_START) && (slot != SLOT_STOP);
    // Middle of SCL high
    assign sample_pt    = busy && qtr_end && (phase == 2'd1);
    assign o_done_pulse = busy && slot_end && (slot == SLOT_STOP);
    assign o_done_cmd   = cmd_q;
    assign o_done_nack  = nack_q;

    // Pin levels per slot and quarter
    always_comb begin
        o_scl     = 1'b1;
        o_sda_low = 1'b0;
        if (busy) begin
            if (slot == SLOT_START) begin
                o_scl     = (phase != 2'd3);
                o_sda_low = (phase != 2'd0);    // SDA falls with SCL high
            end else if (slot == SLOT_STOP) begin
                o_scl     = (phase != 2'd0);
                o_sda_low = !phase[1];          // SDA rises with SCL high
            end else begin
                o_scl     = (phase == 2'd1) || (phase == 2'd2);
                o_sda_low = !frame[26];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy  <= 1'b0;
            qcnt  <= '0;
            phase <= '0;
            slot  <= '0;
        end else if (!busy) begin
            if (accept) begin
                busy  <= 1'b1;
                qcnt  <= '0;
                phase <= '0;
                slot  <= SLOT_START;
            end
        end else begin
            qcnt <= qtr_end ? '0 : qcnt + 1'b1;
            if (qtr_end) phase <= phase + 1'b1;
            if (slot_end) begin
                if (slot == SLOT_STOP) busy <= 1'b0;
                else slot <= slot + 1'b1;
            end
        end
    end

    // Frame, command copy and ack samples
    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd_q  <= i_cmd;
            nack_q <= '0;
            // Ones in the ack positions leave SDA released for the slave
            frame  <= {`CFG_DEV_ADDR, 1'b0, 1'b1,
                       i_cmd.word.reg_addr, i_cmd.word.reg_data[8], 1'b1,
                       i_cmd.word.reg_data[7:0], 1'b1};
        end else begin
            if (busy && slot_end && is_bit_slot) frame <= {frame[25:0], 1'b1};
            if (sample_pt) begin
                case (slot)
                    5'd9:    nack_q[2] <= i_sda;  // Frame bit 8, address byte
                    5'd18:   nack_q[1] <= i_sda;  // Frame bit 17
                    5'd27:   nack_q[0] <= i_sda;  // Frame bit 26
                    default: nack_q    <= nack_q;
                endcase
            end
        end
    end

endmodule

// File: testbench/codec_cfg_assertions.sv
`include "codec_cfg_defines.svh"

module codec_cfg_assertions import codec_cfg_pkg::*; (
    input logic     i_clk,
    input logic     i_rst_n,
    input logic     i_cmd_valid,
    input i2c_cmd_t i_cmd,
    input logic     o_cmd_ready,
    input logic     o_scl,
    input logic     o_sda_low,
    input logic     o_done_pulse,
    input logic [4:0] i_slot
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TXN_CYCLES = 4 * `CFG_I2C_QTR * 29;   // START, 27 bits, STOP

    // START and STOP live in slots 0 and 28
    sda_stable_scl_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_scl && $past(o_scl) && i_slot != 5'd0 && i_slot != 5'd28) |-> $stable(o_sda_low))
        else $error("SDA moved while SCL was high inside a data slot");

    cmd_held_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_cmd_valid && !o_cmd_ready) |=> (i_cmd_valid && $stable(i_cmd)))
        else $error("Command changed or dropped while waiting for ready");

    // Single-cycle done exactly at the end of the transaction
    done_at_txn_end: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_cmd_valid && o_cmd_ready) |-> ##TXN_CYCLES o_done_pulse ##1 !o_done_pulse)
        else $error("Done pulse not a single cycle at the end of the transaction");

endmodule

// File: testbench/codec_cfg_tb.sv
`include "codec_cfg_defines.svh"

module codec_cfg_tb import codec_cfg_pkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_HOST = 40;
    localparam int CYCLE_LIMIT = (`CFG_INIT_LEN + N_HOST) * 4 * `CFG_I2C_QTR * 29 * 2;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        host_valid;
    cfg_word_t   host_word;
    logic        host_ready;
    logic        res_valid;
    i2c_result_t res;
    logic        res_ready;
    logic        scl;
    logic        sda_low;
    logic        sda_line;
    logic        init_done;
    logic        init_error;

    // Slave model state
    logic        ack_drive;
    logic        prev_scl;
    logic        prev_sda;
    logic        in_frame;
    int          bit_cnt;
    int          byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  bytes [3];
    logic        ack_ok [3];

    i2c_cmd_t    exp_cmds [$];
    i2c_result_t exp_res [$];
    int          txn_count;
    int          res_count;
    int          init_seen;
    logic        exp_init_err;
    logic        done_seen;
    int          cycles;

    assign sda_line = !(sda_low || ack_drive);   // Open drain wired AND

    tb_clock_gen tb_clock_gen_inst (.o_clk(clk), .o_rst_n(rst_n));

    codec_cfg_top codec_cfg_top_inst (
        .i_clk(clk), .i_rst_n(rst_n), .i_start(start),
        .i_host_valid(host_valid), .i_host_word(host_word), .o_host_ready(host_ready),
        .o_res_valid(res_valid), .o_res(res), .i_res_ready(res_ready),
        .o_scl(scl), .o_sda_low(sda_low), .i_sda(sda_line),
        .o_init_done(init_done), .o_init_error(init_error)
    );

    bind i2c_write_engine codec_cfg_assertions assertions_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd),
        .o_cmd_ready(o_cmd_ready), .o_scl(o_scl), .o_sda_low(o_sda_low),
        .o_done_pulse(o_done_pulse), .i_slot(slot)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("[ERROR] %0d ns: %s", $time, msg));
    endtask

    task automatic check_result(input i2c_result_t got, input i2c_result_t exp);
        if (got !== exp)
            report_error($sformatf("result %0d got %h/%b/%b expected %h/%b/%b", res_count,
                got.word, got.from_init, got.nack, exp.word, exp.from_init, exp.nack));
    endtask

    task automatic check_word(input cfg_word_t got, input cfg_word_t exp);
        if (got !== exp)
            report_error($sformatf("bus word %0d got %h expected %h", txn_count, got, exp));
    endtask

    task automatic check_addr_byte(input logic [7:0] got);
        if (got !== {`CFG_DEV_ADDR, 1'b0})
            report_error($sformatf("address byte %h expected %h", got, {`CFG_DEV_ADDR, 1'b0}));
    endtask

    task automatic check_flags(input logic got_done, input logic got_err,
                               input logic exp_done, input logic exp_err);
        if (got_done !== exp_done || got_err !== exp_err)
            report_error($sformatf("flags done/error %b/%b expected %b/%b",
                got_done, got_err, exp_done, exp_err));
    endtask

    task automatic load_init_table();
        for (int i = 0; i < `CFG_INIT_LEN; i++)
            exp_cmds.push_back('{word: INIT_TABLE[i], from_init: 1'b1});
    endtask

    // Called on STOP, closes one decoded transaction
    task automatic finish_txn();
        i2c_cmd_t  exp;
        cfg_word_t got;
        logic [2:0] nack;
        if (byte_idx != 3) abort_run("Bus transaction ended before three bytes");
        if (exp_cmds.size() == 0) abort_run("Bus transaction with nothing expected");
        exp  = exp_cmds.pop_front();
        got  = {bytes[1], bytes[2]};
        nack = {!ack_ok[0], !ack_ok[1], !ack_ok[2]};
        check_addr_byte(bytes[0]);
        check_word(got, exp.word);
        exp_res.push_back('{word: exp.word, from_init: exp.from_init, nack: nack});
        if (exp.from_init) begin
            init_seen++;
            exp_init_err = exp_init_err | (nack != 3'b000);
        end
        txn_count++;
    endtask

    // Pin decoder, looks at settled levels between edges
    always @(negedge clk) begin
        if (!rst_n) begin
            prev_scl  = 1'b1;
            prev_sda  = 1'b1;
            ack_drive = 1'b0;
            in_frame  = 1'b0;
        end else begin
            if (prev_scl && scl && prev_sda && !sda_line) begin
                in_frame = 1'b1;                 // START
                bit_cnt  = 0;
                byte_idx = 0;
            end else if (prev_scl && scl && !prev_sda && sda_line) begin
                finish_txn();                    // STOP
                in_frame = 1'b0;
            end else if (!prev_scl && scl && in_frame) begin
                if (bit_cnt < 8) shreg = {shreg[6:0], sda_line};
                bit_cnt++;
            end else if (prev_scl && !scl && in_frame) begin
                if (bit_cnt == 8) begin
                    bytes[byte_idx]  = shreg;
                    ack_ok[byte_idx] = ($urandom % 8) != 0;
                    ack_drive        = ack_ok[byte_idx];
                end else if (bit_cnt == 9) begin
                    ack_drive = 1'b0;            // Release after ack slot
                    bit_cnt   = 0;
                    byte_idx++;
                end
            end
            prev_scl = scl;
            prev_sda = sda_line;
        end
    end

    always @(posedge clk) begin
        if (rst_n && res_valid && res_ready) begin
            if (exp_res.size() == 0) abort_run("Result seen with no matching transaction");
            check_result(res, exp_res.pop_front());
            res_count++;
        end
        if (rst_n && init_done && !done_seen) begin
            done_seen = 1'b1;
            if (init_seen != `CFG_INIT_LEN) report_error("init done before seventh result");
        end
    end

    always begin
        @(posedge clk);
        #2 res_ready = ($urandom % 4) != 0;      // Random back-pressure
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) abort_run("Timeout, run exceeded its cycle limit");
    end

    task automatic pulse_start();
        @(posedge clk);
        #2 start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
    endtask

    task automatic offer_host_words();
        int unsigned gap;
        for (int i = 0; i < N_HOST; i++) begin
            gap = $urandom % 150;
            repeat (gap) @(posedge clk);
            #2;
            host_valid = 1'b1;
            host_word  = cfg_word_t'($urandom);
            do @(posedge clk); while (!host_ready);
            exp_cmds.push_back('{word: host_word, from_init: 1'b0});
            #2 host_valid = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'hcc78));
        start = 1'b0;
        host_valid = 1'b0;
        host_word = '0;
        res_ready = 1'b1;
        ack_drive = 1'b0;
        txn_count = 0;
        res_count = 0;
        init_seen = 0;
        exp_init_err = 1'b0;
        done_seen = 1'b0;
        cycles = 0;
        wait (rst_n);
        load_init_table();
        pulse_start();
        offer_host_words();
        wait (res_count == `CFG_INIT_LEN + N_HOST);
        @(posedge clk);
        #2 check_flags(init_done, init_error, 1'b1, exp_init_err);

        // Replay the table after a second start
        load_init_table();
        pulse_start();
        check_flags(init_done, init_error, 1'b0, 1'b0);
        init_seen = 0;
        exp_init_err = 1'b0;
        done_seen = 1'b0;
        wait (res_count == 2 * `CFG_INIT_LEN + N_HOST);
        @(posedge clk);
        #2 check_flags(init_done, init_error, 1'b1, exp_init_err);
        if (exp_cmds.size() != 0 || exp_res.size() != 0 || res_count != txn_count)
            abort_run("Result count does not match bus transaction count");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;     // 20 ns period
    end

    // Reset held low for 16 rising edges
    initial begin
        o_rst_n = 1'b0;
        repeat (16) @(posedge o_clk);
        #2 o_rst_n = 1'b1;
    end

endmodule
